//--- hdl/qsnd_bus_share.sv
/*
  Hands the sound CPU bus to the 68000 on request. Synchronizes the
  acknowledge and selects who drives the shared address, data and write lines.
*/
`timescale 1ns/1ns

module qsnd_bus_share (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen8,
    input  logic        main_buse_n,
    input  logic [16:1] main_addr,
    input  logic [7:0]  main_dout,
    input  logic        main_ldswn,
    input  logic        busak_n,
    input  logic [15:0] cpu_addr,
    input  logic [7:0]  cpu_dout,
    input  logic        cpu_wr_n,
    input  logic        cpu_mreq_n,
    input  logic        rom_cs,
    input  logic        rom_ok,
    input  logic [7:0]  cpu_din,
    output logic        busrq_n,
    output logic        main_busakn,
    output logic [7:0]  main_din,
    output logic [15:0] bus_addr,
    output logic [7:0]  bus_dout,
    output logic        bus_wr_n,
    output logic        bus_mreq_n
);

    logic [1:0] ack_sync;   // [1] low once the 68000 owns the bus
    logic       rom_ok_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_sync <= 2'b11;
            rom_ok_q <= 1'b0;
        end else begin
            rom_ok_q <= rom_ok;
            if (main_buse_n)
                ack_sync <= 2'b11;
            else if (cen8)
                ack_sync <= {ack_sync[0], busak_n};
        end
    end

    always_ff @(posedge clk) begin
        main_din <= cpu_din;
    end

    assign busrq_n     = main_buse_n;
    assign main_busakn = ack_sync[1] | main_buse_n | (rom_cs & ~rom_ok_q);

    // 68000 side drives the bus once granted
    assign bus_addr   = ack_sync[1] ? cpu_addr : main_addr;
    assign bus_dout   = ack_sync[1] ? cpu_dout : main_dout;
    assign bus_wr_n   = ack_sync[1] ? cpu_wr_n : main_ldswn;
    assign bus_mreq_n = ack_sync[1] & cpu_mreq_n;

endmodule

//--- hdl/qsnd_cpu_timing.sv
/*
  Sound CPU timing: periodic interrupt with acknowledge, and one extra
  wait tick for opcode fetches from 0x4000 upwards.
*/
`timescale 1ns/1ns
`include "qsnd_params.svh"

module qsnd_cpu_timing (
    input  logic         clk,
    input  logic         rst,
    input  logic         cen8,
    input  logic         m1_n,
    input  logic         iorq_n,
    input  logic [15:12] cpu_addr,
    output logic         int_n,
    output logic         cen_cpu
);

    localparam int CW = $clog2(`QSND_INT_PERIOD);

    logic [CW-1:0] cnt;
    logic          cnt_over;
    logic          idle;     // current tick is swallowed
    logic          waited;   // this fetch already got its wait

    assign cnt_over = cnt == CW'(`QSND_INT_PERIOD - 1);
    assign cen_cpu  = cen8 & ~idle;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= cnt_over ? '0 : cnt + 1'b1;
            if (!m1_n && !iorq_n)
                int_n <= 1'b1;   // interrupt acknowledge cycle
            else if (cnt_over)
                int_n <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idle   <= 1'b0;
            waited <= 1'b0;
        end else if (cen8) begin
            if (m1_n)
                waited <= 1'b0;
            if (idle) begin
                idle <= 1'b0;
            end else if (!m1_n && cpu_addr >= 4'h4 && !waited) begin
                idle   <= 1'b1;
                waited <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/qsnd_dsp_mailbox.sv
/*
  Parallel mailbox between the sound CPU and the DSP. Holds the 24-bit
  command, raises the DSP interrupt and latches the sample ROM address.
*/
`timescale 1ns/1ns
`include "qsnd_params.svh"

module qsnd_dsp_mailbox (
    input  logic                    clk,
    input  logic                    rst,
    input  qsnd_pkg::region_t       region,
    input  logic [1:0]              bus_addr,
    input  logic [7:0]              bus_dout,
    input  logic                    pids_n,
    input  logic                    pods_n,
    input  logic [15:0]             pbus_out,
    input  logic [6:0]              dsp_ab,
    input  logic                    dsp_iack,
    output logic [15:0]             pbus_in,
    output logic                    dsp_irq,
    output logic                    dsp_rdy_n,
    output logic [`QSND_SMP_AW-1:0] qsnd_addr
);

    logic [23:0] cmd;
    logic        word_sel;      // 0 low word, 1 top byte
    logic        last_pids_n;
    logic        last_pods_n;
    logic        cmd_wr;
    logic        pids_rise;

    assign cmd_wr    = region == qsnd_pkg::dsp_reg;
    assign pids_rise = pids_n && !last_pids_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dsp_irq     <= 1'b0;
            word_sel    <= 1'b0;
            last_pids_n <= 1'b1;
            last_pods_n <= 1'b1;
        end else begin
            last_pids_n <= pids_n;
            last_pods_n <= pods_n;
            if (cmd_wr && bus_addr == 2'd2) begin
                dsp_irq  <= 1'b1;   // command complete
                word_sel <= 1'b0;
            end else if (pids_rise) begin
                dsp_irq  <= 1'b0;
                word_sel <= ~word_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_wr) begin
            case (bus_addr)
                2'd0:    cmd[7:0]   <= bus_dout;
                2'd1:    cmd[15:8]  <= bus_dout;
                default: cmd[23:16] <= bus_dout;
            endcase
        end
        if (pods_n && !last_pods_n)
            qsnd_addr[15:0] <= pbus_out;
        qsnd_addr[`QSND_SMP_AW-1:16] <= dsp_ab;   // upper bits straight from the DSP
    end

    assign pbus_in   = word_sel ? {8'd0, cmd[23:16]} : cmd[15:0];
    assign dsp_rdy_n = ~(dsp_irq | dsp_iack);

endmodule

//--- hdl/qsnd_memory_map.sv
/*
  Sound CPU memory map: registered region decode, banked ROM address,
  bank/control register, work RAM and the CPU read data selection.
*/
`timescale 1ns/1ns
`include "qsnd_params.svh"

module qsnd_memory_map (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [15:0]             bus_addr,
    input  logic [7:0]              bus_dout,
    input  logic                    bus_wr_n,
    input  logic                    bus_mreq_n,
    input  logic                    cpu_rd_n,
    input  logic [7:0]              rom_data,
    input  logic [7:0]              dec_data,
    input  logic                    dsp_rdy_n,
    output qsnd_pkg::region_t       region,
    output logic [`QSND_ROM_AW-1:0] rom_addr,
    output logic                    rom_cs,
    output logic                    dsp_rst,
    output logic [7:0]              cpu_din
);

    qsnd_pkg::region_t rgn_next;
    logic [3:0]        bank;
    logic [7:0]        ram_mem [0:(1 << `QSND_RAM_AW)-1];
    logic [7:0]        ram_q;
    logic              ram_we;

    always_comb begin
        rgn_next = qsnd_pkg::none;
        if (!bus_addr[15]) begin
            rgn_next = qsnd_pkg::rom_fixed;
        end else if (!bus_addr[14]) begin
            rgn_next = qsnd_pkg::rom_bank;           // 8000-bfff
        end else if (bus_addr[15:12] == 4'hc || bus_addr[15:12] == 4'hf) begin
            rgn_next = qsnd_pkg::ram;
        end else if (bus_addr[15:12] == 4'hd) begin
            if (!bus_wr_n && bus_addr[2:0] <= 3'd2)
                rgn_next = qsnd_pkg::dsp_reg;
            else if (!bus_wr_n && bus_addr[2:0] == 3'd3)
                rgn_next = qsnd_pkg::bank_reg;
            else if (!cpu_rd_n && bus_addr[2:0] == 3'd7)
                rgn_next = qsnd_pkg::status;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            region   <= qsnd_pkg::none;
            rom_addr <= '0;
            bank     <= 4'd0;
            dsp_rst  <= 1'b1;   // DSP held until the CPU releases it
        end else begin
            region <= bus_mreq_n ? qsnd_pkg::none : rgn_next;
            if (!bus_mreq_n) begin
                if (bus_addr[15])
                    rom_addr <= {{(`QSND_ROM_AW-18){1'b0}}, bank, bus_addr[13:0]}
                                + `QSND_BANK_BASE;
                else
                    rom_addr <= {{(`QSND_ROM_AW-15){1'b0}}, bus_addr[14:0]};
            end
            if (region == qsnd_pkg::bank_reg) begin
                bank    <= bus_dout[3:0];
                dsp_rst <= ~bus_dout[7];
            end
        end
    end

    assign rom_cs = region == qsnd_pkg::rom_fixed || region == qsnd_pkg::rom_bank;
    assign ram_we = region == qsnd_pkg::ram && !bus_wr_n;

    // work RAM, shared with the 68000 through the bus mux
    always_ff @(posedge clk) begin
        if (ram_we)
            ram_mem[bus_addr[`QSND_RAM_AW-1:0]] <= bus_dout;
        ram_q <= ram_mem[bus_addr[`QSND_RAM_AW-1:0]];
    end

    always_comb begin
        case (region)
            qsnd_pkg::rom_fixed: cpu_din = dec_data;    // opcodes are encrypted here
            qsnd_pkg::rom_bank:  cpu_din = rom_data;
            qsnd_pkg::ram:       cpu_din = ram_q;
            qsnd_pkg::status:    cpu_din = {dsp_rdy_n, 3'b111, bank};
            default:             cpu_din = 8'hff;
        endcase
    end

endmodule

//--- hdl/qsnd_params.svh
/*
  Size and timing constants for the sound board glue logic.
  Included by the RTL files that need them.
*/
`ifndef QSND_PARAMS_SVH
`define QSND_PARAMS_SVH

// program ROM byte address, 512 kB
`define QSND_ROM_AW 19
// sample ROM address, 8 MB
`define QSND_SMP_AW 23
// work RAM address, 8 kB
`define QSND_RAM_AW 13

`define QSND_BANK_BASE 19'h8000   // added to banked ROM addresses
`define QSND_INT_PERIOD 32000     // cen8 ticks between CPU interrupts

`endif

//--- hdl/qsnd_pkg.sv
/*
  Shared types of the sound board. Modules refer to them by scoped name.
*/
package qsnd_pkg;

    // decoded target of a sound CPU bus access
    typedef enum logic [2:0] {
        none,
        rom_fixed,
        rom_bank,
        ram,
        dsp_reg,
        bank_reg,
        status
    } region_t;

    // one channel of DSP audio
    typedef logic signed [15:0] sample_t;

endpackage

//--- hdl/qsnd_serial_audio.sv
/*
  Converts the DSP serial stereo output to parallel samples.
  psel picks the channel and its rising edge publishes the pair.
*/
`timescale 1ns/1ns

module qsnd_serial_audio (
    input  logic              clk,
    input  logic              rst,
    input  logic              sdo,
    input  logic              ock,
    input  logic              psel,
    output qsnd_pkg::sample_t left,
    output qsnd_pkg::sample_t right,
    output logic              sample
);

    qsnd_pkg::sample_t sh_left;
    qsnd_pkg::sample_t sh_right;
    logic              sdo_q, ock_q, psel_q;   // input stage
    logic              last_ock, last_psel;
    logic              psel_rise;

    assign psel_rise = psel_q && !last_psel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ock_q     <= 1'b0;
            psel_q    <= 1'b0;
            last_ock  <= 1'b0;
            last_psel <= 1'b0;
            sample    <= 1'b0;
        end else begin
            ock_q     <= ock;
            psel_q    <= psel;
            last_ock  <= ock_q;
            last_psel <= psel_q;
            sample    <= psel_rise;
        end
    end

    always_ff @(posedge clk) begin
        sdo_q <= sdo;
        if (!ock_q && last_ock) begin
            // MSB first
            if (!psel_q)
                sh_left  <= {sh_left[14:0], sdo_q};
            else
                sh_right <= {sh_right[14:0], sdo_q};
        end
        if (psel_rise) begin
            left  <= sh_left;
            right <= sh_right;
        end
    end

endmodule

//--- hdl/qsnd_sound.sv
/*
  Sound board glue top level. CPU, DSP, ROM and 68000 pins are brought out
  so that the cores, or a testbench, connect around it.
*/
`timescale 1ns/1ns
`include "qsnd_params.svh"

module qsnd_sound (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen8,
    // 68000 side
    input  logic [16:1]             main_addr,
    input  logic [7:0]              main_dout,
    output logic [7:0]              main_din,
    input  logic                    main_ldswn,
    input  logic                    main_buse_n,
    output logic                    main_busakn,
    // sound CPU pins
    input  logic [15:0]             cpu_addr,
    input  logic [7:0]              cpu_dout,
    output logic [7:0]              cpu_din,
    input  logic                    m1_n,
    input  logic                    mreq_n,
    input  logic                    iorq_n,
    input  logic                    rd_n,
    input  logic                    wr_n,
    input  logic                    busak_n,
    output logic                    busrq_n,
    output logic                    int_n,
    output logic                    cen_cpu,
    // program ROM
    output logic [`QSND_ROM_AW-1:0] rom_addr,
    output logic                    rom_cs,
    input  logic [7:0]              rom_data,
    input  logic [7:0]              dec_data,   // after opcode decryption
    input  logic                    rom_ok,
    // DSP pins
    output logic                    dsp_rst,
    output logic [15:0]             pbus_in,
    input  logic [15:0]             pbus_out,
    input  logic                    pids_n,
    input  logic                    pods_n,
    input  logic [6:0]              dsp_ab,
    input  logic                    dsp_iack,
    output logic                    dsp_irq,
    output logic [`QSND_SMP_AW-1:0] qsnd_addr,
    input  logic                    sdo,
    input  logic                    ock,
    input  logic                    psel,
    // audio out
    output qsnd_pkg::sample_t       left,
    output qsnd_pkg::sample_t       right,
    output logic                    sample
);

    logic [15:0]       bus_addr;
    logic [7:0]        bus_dout;
    logic              bus_wr_n;
    logic              bus_mreq_n;
    logic              dsp_rdy_n;
    qsnd_pkg::region_t region;

    qsnd_bus_share u_bus_share (
        .clk         (clk),
        .rst         (rst),
        .cen8        (cen8),
        .main_buse_n (main_buse_n),
        .main_addr   (main_addr),
        .main_dout   (main_dout),
        .main_ldswn  (main_ldswn),
        .busak_n     (busak_n),
        .cpu_addr    (cpu_addr),
        .cpu_dout    (cpu_dout),
        .cpu_wr_n    (wr_n),
        .cpu_mreq_n  (mreq_n),
        .rom_cs      (rom_cs),
        .rom_ok      (rom_ok),
        .cpu_din     (cpu_din),
        .busrq_n     (busrq_n),
        .main_busakn (main_busakn),
        .main_din    (main_din),
        .bus_addr    (bus_addr),
        .bus_dout    (bus_dout),
        .bus_wr_n    (bus_wr_n),
        .bus_mreq_n  (bus_mreq_n)
    );

    qsnd_memory_map u_memory_map (
        .clk        (clk),
        .rst        (rst),
        .bus_addr   (bus_addr),
        .bus_dout   (bus_dout),
        .bus_wr_n   (bus_wr_n),
        .bus_mreq_n (bus_mreq_n),
        .cpu_rd_n   (rd_n),
        .rom_data   (rom_data),
        .dec_data   (dec_data),
        .dsp_rdy_n  (dsp_rdy_n),
        .region     (region),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .dsp_rst    (dsp_rst),
        .cpu_din    (cpu_din)
    );

    qsnd_dsp_mailbox u_dsp_mailbox (
        .clk       (clk),
        .rst       (rst),
        .region    (region),
        .bus_addr  (bus_addr[1:0]),
        .bus_dout  (bus_dout),
        .pids_n    (pids_n),
        .pods_n    (pods_n),
        .pbus_out  (pbus_out),
        .dsp_ab    (dsp_ab),
        .dsp_iack  (dsp_iack),
        .pbus_in   (pbus_in),
        .dsp_irq   (dsp_irq),
        .dsp_rdy_n (dsp_rdy_n),
        .qsnd_addr (qsnd_addr)
    );

    qsnd_serial_audio u_serial_audio (
        .clk    (clk),
        .rst    (rst),
        .sdo    (sdo),
        .ock    (ock),
        .psel   (psel),
        .left   (left),
        .right  (right),
        .sample (sample)
    );

    qsnd_cpu_timing u_cpu_timing (
        .clk      (clk),
        .rst      (rst),
        .cen8     (cen8),
        .m1_n     (m1_n),
        .iorq_n   (iorq_n),
        .cpu_addr (cpu_addr[15:12]),
        .int_n    (int_n),
        .cen_cpu  (cen_cpu)
    );

endmodule

//--- qsnd_sound.f
+incdir+hdl
hdl/qsnd_pkg.sv
hdl/qsnd_memory_map.sv
hdl/qsnd_dsp_mailbox.sv
hdl/qsnd_serial_audio.sv
hdl/qsnd_cpu_timing.sv
hdl/qsnd_bus_share.sv
hdl/qsnd_sound.sv
tests/tb_qsnd_sound.sv

//--- tests/tb_qsnd_sound.sv
/*
  Testbench for the sound board glue. Plays sound CPU, DSP and 68000 from
  an operation table, then checks the CPU interrupt and fetch wait state.
*/
`timescale 1ns/1ns
`include "qsnd_params.svh"

module tb_qsnd_sound;

    localparam int K_CPU_WR = 0;
    localparam int K_CPU_RD = 1;
    localparam int K_MAIN_WR = 2;
    localparam int K_DSP = 3;        // addr[0] picks pods_n, addr[15:9] is dsp_ab
    localparam int K_SERIAL = 4;     // addr left word, data right word

    logic clk = 0, rst = 1, cen8 = 0;
    logic [16:1] main_addr = 0;
    logic [7:0] main_dout = 0, main_din;
    logic main_ldswn = 1, main_buse_n = 1, main_busakn;
    logic [15:0] cpu_addr = 0;
    logic [7:0] cpu_dout = 0, cpu_din;
    logic m1_n = 1, mreq_n = 1, iorq_n = 1, rd_n = 1, wr_n = 1, busak_n = 1;
    logic busrq_n, int_n, cen_cpu, rom_cs, dsp_rst, dsp_irq, sample;
    logic [`QSND_ROM_AW-1:0] rom_addr;
    logic [7:0] rom_data = 8'h3c, dec_data = 8'hc3;
    logic rom_ok = 1;
    logic [15:0] pbus_in, pbus_out = 0;
    logic pids_n = 1, pods_n = 1, dsp_iack = 0, sdo = 0, ock = 0, psel = 0;
    logic [6:0] dsp_ab = 0;
    logic [`QSND_SMP_AW-1:0] qsnd_addr;
    qsnd_pkg::sample_t left, right;

    int op_kind [0:63];
    logic [15:0] op_addr [0:63];
    logic [15:0] op_data [0:63];
    logic [31:0] op_exp [0:63];
    int n_ops = 0;
    int errors = 0;
    logic [31:0] seed = 32'h6c20;
    int ticks = 0;           // cen8 ticks since reset release
    int int_fall_ticks = -1;

    qsnd_sound UUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cen8 <= ~cen8;
        if (!rst && cen8)
            ticks <= ticks + 1;
        if (!rst && !int_n && int_fall_ticks < 0)
            int_fall_ticks <= ticks;
    end

    function automatic logic [15:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[30:15];
    endfunction

    task automatic add_op(input int kind, input logic [15:0] addr,
                          input logic [15:0] data, input logic [31:0] exp);
        op_kind[n_ops] = kind;
        op_addr[n_ops] = addr;
        op_data[n_ops] = data;
        op_exp[n_ops]  = exp;
        n_ops++;
    endtask

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            errors++;
            $display("Mismatch at %0t: %s", $time, msg);
        end
    endtask

    // one bus access held long enough for the registered decode and RAM
    task automatic cpu_access(input logic [15:0] addr, input logic [7:0] data,
                              input logic write, output logic [7:0] rdata,
                              output logic cs);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_dout <= data;
        mreq_n   <= 0;
        wr_n     <= !write;
        rd_n     <= write;
        repeat (3) @(posedge clk);
        rdata = cpu_din;
        cs    = rom_cs;
        mreq_n <= 1;
        wr_n   <= 1;
        rd_n   <= 1;
        repeat (2) @(posedge clk);
    endtask

    task automatic serial_word(input logic [15:0] w);
        for (int i = 15; i >= 0; i--) begin
            sdo <= w[i];
            ock <= 1;
            repeat (2) @(posedge clk);
            ock <= 0;
            repeat (2) @(posedge clk);
        end
    endtask

    task automatic wait_grant(output int n);
        n = 0;
        for (int i = 0; i < 100; i++) begin
            @(posedge clk);
            if (!main_busakn)
                return;
            if (cen8)
                n++;
        end
        errors++;
        $display("Timeout: the 68000 bus grant never came");
    endtask

    task automatic run_op(input int i);
        logic [7:0] rd;
        logic cs;
        int n;
        case (op_kind[i])
            K_CPU_WR: begin
                cpu_access(op_addr[i], op_data[i][7:0], 1, rd, cs);
                if (op_addr[i] == 16'hd003)
                    check(dsp_rst == op_exp[i][0], "dsp_rst after bank write");
                if (op_addr[i] == 16'hd002)
                    check(dsp_irq && pbus_in == op_exp[i][15:0], "command low word");
            end
            K_CPU_RD: begin
                cpu_access(op_addr[i], 8'h00, 0, rd, cs);
                if (!op_addr[i][15] || !op_addr[i][14]) begin
                    check(rom_addr == op_exp[i][`QSND_ROM_AW-1:0], "rom_addr");
                    check(cs == 1, "rom_cs during a ROM read");
                    // fixed ROM gives decrypted opcodes and banked ROM raw data
                    check(rd == (op_addr[i][15] ? rom_data : dec_data), "ROM read data");
                end else begin
                    check(rd == op_exp[i][7:0], "cpu read data");
                    check(cs == 0, "rom_cs outside ROM");
                end
            end
            K_DSP: begin
                @(posedge clk);
                pbus_out <= op_data[i];
                dsp_ab   <= op_addr[i][15:9];
                if (op_addr[i][0])
                    pods_n <= 0;
                else
                    pids_n <= 0;
                repeat (2) @(posedge clk);
                pods_n <= 1;
                pids_n <= 1;
                repeat (3) @(posedge clk);
                if (op_addr[i][0])
                    check(qsnd_addr == op_exp[i][`QSND_SMP_AW-1:0], "sample ROM address");
                else
                    check(!dsp_irq && pbus_in == op_exp[i][15:0], "command top byte");
            end
            K_SERIAL: begin
                @(posedge clk);
                psel <= 1;
                repeat (4) @(posedge clk);
                serial_word(op_data[i]);
                psel <= 0;
                repeat (4) @(posedge clk);
                serial_word(op_addr[i]);
                psel <= 1;
                n = 0;
                while (n < 20 && sample !== 1'b1) begin
                    @(posedge clk);
                    n++;
                end
                check(n == 3, "sample strobe latency");
                check({left, right} == op_exp[i], "stereo sample words");
                @(posedge clk);
                check(sample == 0, "sample strobe longer than one cycle");
            end
            K_MAIN_WR: begin
                @(posedge clk);
                main_addr   <= op_addr[i];
                main_dout   <= op_data[i][7:0];
                main_buse_n <= 0;
                if (!op_addr[i][15])
                    rom_ok <= 0;
                repeat (4) @(posedge clk);
                check(busrq_n == 0, "busrq_n follows main_buse_n");
                busak_n <= 0;
                if (op_addr[i][15]) begin
                    wait_grant(n);
                    check(n == 2, "main_busakn delay in cen8 ticks");
                    main_ldswn <= 0;
                    repeat (3) @(posedge clk);
                    main_ldswn <= 1;
                    @(posedge clk);
                    check(main_din == op_data[i][7:0], "main_din after 68000 write");
                end else begin
                    repeat (12) @(posedge clk);
                    check(main_busakn == 1, "main_busakn held during ROM wait");
                    rom_ok <= 1;
                    wait_grant(n);
                end
                @(posedge clk);
                main_buse_n <= 1;
                busak_n     <= 1;
                @(posedge clk);
                check(main_busakn == 1, "main_busakn release");
                repeat (2) @(posedge clk);
            end
            default: begin
                errors++;
                $display("Unknown operation kind in table entry %0d", i);
            end
        endcase
    endtask

    task automatic count_fetch(input logic [15:0] addr, output int lost);
        lost = 0;
        @(posedge clk);
        cpu_addr <= addr;
        m1_n     <= 0;
        for (int i = 0; i < 12; i++) begin
            @(posedge clk);
            if (i == 5)
                m1_n <= 1;
            if (cen8 && !cen_cpu)
                lost++;
        end
    endtask

    initial begin
        logic [7:0] b0, b1, b2, r;
        logic [15:0] w0, w1, p;
        logic [6:0] ab;
        int lost;
        b0 = lcg_next();
        b1 = lcg_next();
        b2 = lcg_next();
        r  = lcg_next();
        w0 = lcg_next();
        w1 = lcg_next();
        p  = lcg_next();
        ab = lcg_next();
        add_op(K_CPU_WR, 16'hd003, 16'h00, 1);
        add_op(K_CPU_RD, 16'h1234, 0, 32'h1234);
        add_op(K_CPU_RD, 16'h9234, 0, 0 * 32'h4000 + 32'h1234 + `QSND_BANK_BASE);
        add_op(K_CPU_WR, 16'hd003, 16'h05, 1);
        add_op(K_CPU_RD, 16'h9234, 0, 5 * 32'h4000 + 32'h1234 + `QSND_BANK_BASE);
        add_op(K_CPU_RD, 16'h1234, 0, 32'h1234);
        add_op(K_CPU_WR, 16'hd003, 16'h85, 0);   // release the DSP
        add_op(K_CPU_RD, 16'hd007, 0, {1'b1, 3'b111, 4'h5});
        add_op(K_CPU_WR, 16'hd000, b0, 0);
        add_op(K_CPU_WR, 16'hd001, b1, 0);
        add_op(K_CPU_WR, 16'hd002, b2, {b1, b0});
        add_op(K_CPU_RD, 16'hd007, 0, {1'b0, 3'b111, 4'h5});   // irq pending
        add_op(K_DSP, 16'h0000, 0, {8'h00, b2});
        add_op(K_DSP, {ab, 9'h001}, p, {ab, p});
        add_op(K_CPU_RD, 16'hd055, 0, 8'hff);                 // unmapped
        add_op(K_CPU_WR, 16'hc010, r, 0);
        add_op(K_CPU_RD, 16'hc010, 0, r);
        add_op(K_CPU_WR, 16'hf123, ~r, 0);
        add_op(K_CPU_RD, 16'hf123, 0, ~r);
        add_op(K_SERIAL, w0, w1, {w0, w1});
        add_op(K_MAIN_WR, 16'hc2a0, b1, 0);
        add_op(K_CPU_RD, 16'hc2a0, 0, b1);
        add_op(K_MAIN_WR, 16'h0400, 0, 0);                   // ROM wait hold
        repeat (16) @(posedge clk);
        rst <= 0;
        for (int i = 0; i < n_ops; i++)
            run_op(i);
        count_fetch(16'h5000, lost);
        check(lost == 1, "wait ticks for a fetch at 0x5000");
        count_fetch(16'h1000, lost);
        check(lost == 0, "wait ticks for a fetch at 0x1000");
        cpu_addr <= 0;
        while (int_fall_ticks < 0)
            @(posedge clk);
        check(int_fall_ticks == `QSND_INT_PERIOD, "interrupt period");
        @(posedge clk);
        m1_n   <= 0;
        iorq_n <= 0;
        repeat (4) @(posedge clk);
        m1_n   <= 1;
        iorq_n <= 1;
        repeat (2) @(posedge clk);
        check(int_n == 1, "int_n after acknowledge");
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // each cen8 tick is two clock cycles of 4 ns
    initial begin
        #1;
        #((n_ops * 200 + 4 * `QSND_INT_PERIOD) * 4);
        $display("Timeout: the tests did not complete in time");
        $display("Errors: %0d", errors + 1);
        $display("Finished with errors");
        $finish;
    end

endmodule
